// ==== beam_measure.sv ====
// beam measurement: position counters, active area edges, size and geometry change count
`include "video_crop_config.svh"

module beam_measure
	import video_crop_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      hsync_n,
	input  logic                      hblank,
	input  logic                      vblank,
	output coord_t                    h_count,
	output coord_t                    v_count,
	output coord_t                    h_act_start,
	output coord_t                    h_act_end,
	output coord_t                    v_act_start,
	output coord_t                    v_act_end,
	output logic                      line_start,
	output coord_t                    h_size,
	output coord_t                    v_size,
	output logic [`VC_GEOM_CNT_W-1:0] geometry_count
);

	logic   old_hsync;
	logic   old_hblank;
	logic   old_vblank;
	logic   hbl_fall, hbl_rise;
	logic   vbl_fall, vbl_rise;
	coord_t snap_h, snap_v; // sizes seen at the previous frame start

	assign line_start = old_hsync & ~hsync_n; // hsync falling edge
	assign hbl_fall   = old_hblank & ~hblank;
	assign hbl_rise   = ~old_hblank & hblank;
	assign vbl_fall   = old_vblank & ~vblank;
	assign vbl_rise   = ~old_vblank & vblank;

	// beam counters
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hsync  <= 1'b1;
			old_hblank <= 1'b1;
			old_vblank <= 1'b1;
			h_count    <= '0;
			v_count    <= '0;
		end else begin
			old_hsync  <= hsync_n;
			old_hblank <= hblank;
			old_vblank <= vblank;

			if (!hsync_n) h_count <= '0;
			else          h_count <= h_count + 1'b1;

			if (line_start) v_count <= v_count + 1'b1;
			if (vbl_rise)   v_count <= '0; // new frame
		end
	end

	// active area edges and sizes
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			h_act_start <= '0;
			h_act_end   <= '0;
			v_act_start <= '0;
			v_act_end   <= '0;
			h_size      <= '0;
			v_size      <= '0;
		end else begin
			if (hbl_fall) h_act_start <= h_count;
			if (hbl_rise) h_act_end   <= h_count;
			if (vbl_fall) v_act_start <= v_count;
			if (vbl_rise) v_act_end   <= v_count;

			// width taken from visible lines only
			if (hbl_rise && !vblank) h_size <= h_count - h_act_start;
			if (vbl_rise)            v_size <= v_count - v_act_start;
		end
	end

	// count frames whose geometry differs from the one before
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			snap_h         <= '0;
			snap_v         <= '0;
			geometry_count <= '0;
		end else if (vbl_fall) begin
			snap_h <= h_size;
			snap_v <= v_size;
			if (h_size != snap_h || v_size != snap_v) begin
				geometry_count <= geometry_count + 1'b1;
			end
		end
	end

endmodule

// ==== crop_adjust.sv ====
// crop offset register: alt modifier and the four signed blanking offsets
`include "video_crop_config.svh"

module crop_adjust
	import video_crop_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      cmd_valid,
	input  crop_cmd_t cmd,
	output coord_t    crop_left,
	output coord_t    crop_right,
	output coord_t    crop_top,
	output coord_t    crop_bottom
);

	localparam coord_t HSTEP = coord_t'(`VC_HSTEP);
	localparam coord_t VSTEP = coord_t'(`VC_VSTEP);

	logic alt; // alt held, keys move bottom/right edges

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			alt         <= 1'b0;
			crop_left   <= '0;
			crop_right  <= '0;
			crop_top    <= '0;
			crop_bottom <= '0;
		end else if (cmd_valid) begin
			case (cmd)
				CMD_CLEAR: begin
					crop_left   <= '0;
					crop_right  <= '0;
					crop_top    <= '0;
					crop_bottom <= '0;
				end
				CMD_UP: begin
					if (alt) crop_bottom <= crop_bottom + VSTEP;
					else     crop_top    <= crop_top + VSTEP;
				end
				CMD_DOWN: begin
					if (alt) crop_bottom <= crop_bottom - VSTEP;
					else     crop_top    <= crop_top - VSTEP;
				end
				CMD_LEFT: begin
					if (alt) crop_right <= crop_right + HSTEP;
					else     crop_left  <= crop_left + HSTEP;
				end
				CMD_RIGHT: begin
					if (alt) crop_right <= crop_right - HSTEP;
					else     crop_left  <= crop_left - HSTEP;
				end
				CMD_ALT_ON:  alt <= 1'b1;
				CMD_ALT_OFF: alt <= 1'b0;
				default: ;
			endcase
		end
	end

endmodule

// ==== crop_blank_gen.sv ====
// crop blanking generator: trimmed h/v blanking window and registered display enable
module crop_blank_gen
	import video_crop_pkg::*;
(
	input  logic   clk_sys,
	input  logic   reset,
	input  logic   hsync_n,
	input  coord_t h_count,
	input  coord_t v_count,
	input  coord_t h_act_start,
	input  coord_t h_act_end,
	input  coord_t v_act_start,
	input  coord_t v_act_end,
	input  logic   line_start,
	input  coord_t crop_left,
	input  coord_t crop_right,
	input  coord_t crop_top,
	input  coord_t crop_bottom,
	output logic   de
);

	coord_t line_left, line_right;   // offsets in use for this line
	coord_t frame_top, frame_bottom; // offsets in use for this frame
	coord_t h_clr_pos, h_set_pos;
	coord_t v_clr_pos, v_set_pos;
	logic   hbl_trim;
	logic   vbl_trim;

	// modulo-width sums, so negative offsets widen the window
	assign h_clr_pos = h_act_start + line_left;
	assign h_set_pos = h_act_end + line_right;
	assign v_clr_pos = v_act_start + frame_top;
	assign v_set_pos = v_act_end + frame_bottom;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			line_left    <= '0;
			line_right   <= '0;
			frame_top    <= '0;
			frame_bottom <= '0;
			hbl_trim     <= 1'b1;
			vbl_trim     <= 1'b1;
			de           <= 1'b0;
		end else begin
			if (line_start) begin
				line_left  <= crop_left;
				line_right <= crop_right;
			end
			if (line_start && v_count == '0) begin // once per frame, in vblank
				frame_top    <= crop_top;
				frame_bottom <= crop_bottom;
			end

			if (h_count == h_clr_pos) hbl_trim <= 1'b0;
			if (h_count == h_set_pos) hbl_trim <= 1'b1;

			if (line_start) begin
				if (v_count == v_clr_pos) vbl_trim <= 1'b0;
				if (v_count == v_set_pos) vbl_trim <= 1'b1;
			end

			de <= ~hbl_trim & ~vbl_trim & hsync_n;
		end
	end

endmodule

// ==== crop_key_decode.sv ====
// crop key decoder: keyboard level toggles to single-cycle crop commands
`include "video_crop_config.svh"

module crop_key_decode
	import video_crop_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [7:0] kbd_data,
	input  logic [1:0] kbd_type,
	input  logic       kbd_level,
	output logic       cmd_valid,
	output crop_cmd_t  cmd
);

	logic      old_level;
	logic      kbd_toggle;
	logic      key_hit;
	crop_cmd_t key_cmd;

	// every new event flips the level once
	assign kbd_toggle = old_level ^ kbd_level;

	always_comb begin
		key_hit = 1'b1;
		key_cmd = CMD_CLEAR;
		case (kbd_data)
			`VC_KEY_BACKSPACE: key_cmd = CMD_CLEAR;
			`VC_KEY_UP:        key_cmd = CMD_UP;
			`VC_KEY_DOWN:      key_cmd = CMD_DOWN;
			`VC_KEY_LEFT:      key_cmd = CMD_LEFT;
			`VC_KEY_RIGHT:     key_cmd = CMD_RIGHT;
			`VC_KEY_ALT_L_DN, `VC_KEY_ALT_R_DN: key_cmd = CMD_ALT_ON;
			`VC_KEY_ALT_L_UP, `VC_KEY_ALT_R_UP: key_cmd = CMD_ALT_OFF;
			default: key_hit = 1'b0; // not a crop key
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			old_level <= kbd_level;
			cmd_valid <= kbd_toggle && (kbd_type == `VC_EVT_KEYBOARD) && key_hit;
		end
	end

	// command word only matters alongside cmd_valid
	always_ff @(posedge clk_sys) begin
		if (kbd_toggle) begin
			cmd <= key_cmd;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the video crop testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f video_crop.f \
	--top-module tb_video_crop \
	-o sim_video_crop

./obj_dir/sim_video_crop > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
	exit 0
else
	exit 1
fi

// ==== tb_video_crop.sv ====
// video crop testbench: video source model, key stimulus, reference model and de checker
`include "video_crop_config.svh"

module tb_video_crop;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LINE_LEN  = 80;
	localparam int FRAME_LEN = 40;
	localparam int MAX_CYCLES = 60000; // ~17 frames of 3200 cycles plus margin

	logic       clk_sys;
	logic       reset;
	logic [7:0] kbd_data;
	logic [1:0] kbd_type;
	logic       kbd_level;
	logic       hsync_n;
	logic       hblank;
	logic       vblank;
	logic       de;
	logic [`VC_COORD_W-1:0]    h_size;
	logic [`VC_COORD_W-1:0]    v_size;
	logic [`VC_GEOM_CNT_W-1:0] geometry_count;

	// source position and mode
	int hpos;
	int vline;
	bit mode_b;
	int frame_cnt;

	// offsets tracked from the keys sent
	int  ref_l, ref_r, ref_t, ref_b;
	bit  ref_alt;
	int  change_cnt;

	// checker state
	int seen_change;
	int skip_frames;
	int line_de;
	int lines_on;
	int checks_done;
	int cycles;

	video_crop_top i_dut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.kbd_data       (kbd_data),
		.kbd_type       (kbd_type),
		.kbd_level      (kbd_level),
		.hsync_n        (hsync_n),
		.hblank         (hblank),
		.vblank         (vblank),
		.de             (de),
		.h_size         (h_size),
		.v_size         (v_size),
		.geometry_count (geometry_count)
	);

	always #2 clk_sys = ~clk_sys;

	function automatic int act_w();
		return mode_b ? 40 : 50;
	endfunction

	function automatic int act_h();
		return mode_b ? 24 : 30;
	endfunction

	// expected de cycles per line and enabled lines per frame
	function automatic void crop_ref(input int w, input int h, input int l, input int r,
			input int t, input int b, output int de_per_line, output int lines);
		de_per_line = w + r - l;
		lines       = h + b - t;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
		$display("TB FAILED");
	endtask

	// apply a key event to the tracked offsets
	task automatic track_key(input logic [7:0] data, input logic [1:0] typ);
		if (typ == `VC_EVT_KEYBOARD) begin
			case (data)
				`VC_KEY_BACKSPACE: begin
					ref_l = 0;
					ref_r = 0;
					ref_t = 0;
					ref_b = 0;
				end
				`VC_KEY_UP:    if (ref_alt) ref_b += `VC_VSTEP; else ref_t += `VC_VSTEP;
				`VC_KEY_DOWN:  if (ref_alt) ref_b -= `VC_VSTEP; else ref_t -= `VC_VSTEP;
				`VC_KEY_LEFT:  if (ref_alt) ref_r += `VC_HSTEP; else ref_l += `VC_HSTEP;
				`VC_KEY_RIGHT: if (ref_alt) ref_r -= `VC_HSTEP; else ref_l -= `VC_HSTEP;
				`VC_KEY_ALT_L_DN, `VC_KEY_ALT_R_DN: ref_alt = 1'b1;
				`VC_KEY_ALT_L_UP, `VC_KEY_ALT_R_UP: ref_alt = 1'b0;
				default: ;
			endcase
		end
	endtask

	task automatic send_key(input logic [7:0] data, input logic [1:0] typ);
		@(posedge clk_sys);
		track_key(data, typ);
		change_cnt++;
		@(negedge clk_sys);
		kbd_data  = data;
		kbd_type  = typ;
		kbd_level = ~kbd_level; // one toggle per event
		repeat (3) @(negedge clk_sys);
	endtask

	// horizontal key that keeps the moved offset within +-8
	function automatic logic [7:0] pick_h(input bit grow);
		int cur;
		cur = ref_alt ? ref_r : ref_l;
		if (grow && cur + `VC_HSTEP > 8) return `VC_KEY_RIGHT;
		if (!grow && cur - `VC_HSTEP < -8) return `VC_KEY_LEFT;
		return grow ? `VC_KEY_LEFT : `VC_KEY_RIGHT;
	endfunction

	// bottom stays at or below zero as the beam never passes the active end
	function automatic logic [7:0] pick_v(input bit grow);
		int cur;
		int hi;
		cur = ref_alt ? ref_b : ref_t;
		hi  = ref_alt ? 0 : 3;
		if (grow && cur + `VC_VSTEP > hi) return `VC_KEY_DOWN;
		if (!grow && cur - `VC_VSTEP < -3) return `VC_KEY_UP;
		return grow ? `VC_KEY_UP : `VC_KEY_DOWN;
	endfunction

	task automatic wait_frames(input int last);
		while (frame_cnt < last) @(posedge clk_sys);
	endtask

	// source model and checker, sampled and driven on the falling edge
	always @(negedge clk_sys) begin
		int exp_w;
		int exp_h;
		crop_ref(act_w(), act_h(), ref_l, ref_r, ref_t, ref_b, exp_w, exp_h);
		if (change_cnt != seen_change) begin
			seen_change = change_cnt;
			skip_frames = 2; // settle window
		end
		if (de) line_de++;
		if (hpos == LINE_LEN - 1) begin
			if (line_de != 0) begin
				lines_on++;
				if (skip_frames == 0) begin
					assert (line_de == exp_w) else begin
						report_mismatch($sformatf("de width %0d, expected %0d", line_de, exp_w));
						$fatal(1);
					end
				end
			end
			line_de = 0;
			if (vline == FRAME_LEN - 1) begin
				if (skip_frames == 0) begin
					assert (lines_on == exp_h) else begin
						report_mismatch($sformatf("lines %0d, expected %0d", lines_on, exp_h));
						$fatal(1);
					end
					assert (int'(h_size) == act_w() && int'(v_size) == act_h()) else begin
						report_mismatch($sformatf("size %0dx%0d", h_size, v_size));
						$fatal(1);
					end
					checks_done++;
				end else begin
					skip_frames--;
				end
				lines_on = 0;
				frame_cnt++;
			end
		end
		hpos++;
		if (hpos == LINE_LEN) begin
			hpos = 0;
			vline = (vline == FRAME_LEN - 1) ? 0 : vline + 1;
		end
		hsync_n = (hpos >= 8);
		hblank  = !(hpos >= 20 && hpos < 20 + act_w());
		vblank  = !(vline >= 6 && vline < 6 + act_h());
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TB FAILED");
			$fatal(1);
		end
	end

	initial begin
		int sel;
		int geom_base;
		void'($urandom(32'h3cb1_d318));
		clk_sys = 0;
		reset = 1;
		kbd_data = 0;
		kbd_type = 0;
		kbd_level = 0;
		hsync_n = 0;
		hblank = 1;
		vblank = 1;
		skip_frames = 2;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 0;

		wait_frames(3); // full window in mode A checked in frame 2

		// random crop keys with alt toggled along the way
		for (int i = 0; i < 12; i++) begin
			sel = $urandom % 6;
			if (sel == 0) begin
				if (ref_alt) send_key(($urandom % 2) ? `VC_KEY_ALT_L_UP : `VC_KEY_ALT_R_UP, 2'd3);
				else send_key(($urandom % 2) ? `VC_KEY_ALT_L_DN : `VC_KEY_ALT_R_DN, 2'd3);
			end else if (sel < 3) begin
				send_key(pick_h($urandom % 2), 2'd3);
			end else begin
				send_key(pick_v($urandom % 2), 2'd3);
			end
		end
		send_key(`VC_KEY_ALT_L_DN, 2'd3);
		send_key(pick_h(1'b0), 2'd3);
		send_key(pick_v(1'b0), 2'd3);
		send_key(`VC_KEY_ALT_R_UP, 2'd3); // back to left and top
		send_key(pick_h(1'b1), 2'd3);
		send_key(pick_v(1'b1), 2'd3);
		wait_frames(6);

		// known nonzero offsets, then events that must leave them alone
		send_key(`VC_KEY_BACKSPACE, 2'd3);
		send_key(`VC_KEY_LEFT, 2'd3);
		send_key(`VC_KEY_UP, 2'd3);
		send_key(`VC_KEY_LEFT, 2'd2);
		send_key(`VC_KEY_UP, 2'd0);
		send_key(8'h1C, 2'd3);
		send_key(8'h4A, 2'd3);
		wait_frames(9);

		send_key(`VC_KEY_BACKSPACE, 2'd3); // full window again
		wait_frames(12);

		@(negedge clk_sys);
		geom_base = int'(geometry_count);
		@(posedge clk_sys);
		mode_b = 1'b1;
		change_cnt++;
		wait_frames(14);
		@(negedge clk_sys);
		assert (int'(geometry_count) == geom_base + 1) else begin
			report_mismatch($sformatf("geometry_count %0d after mode change", geometry_count));
			$fatal(1);
		end
		wait_frames(17);
		@(negedge clk_sys);
		assert (int'(geometry_count) == geom_base + 1) else begin
			report_mismatch($sformatf("geometry_count %0d in steady mode B", geometry_count));
			$fatal(1);
		end

		if (checks_done > 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("no frame was checked during the run");
			$display("TB FAILED");
			$fatal(1);
		end
	end

endmodule

// ==== video_crop.f ====
+incdir+.
video_crop_pkg.sv
crop_key_decode.sv
crop_adjust.sv
beam_measure.sv
crop_blank_gen.sv
video_crop_top.sv
tb_video_crop.sv

// ==== video_crop_config.svh ====
// video crop configuration: key codes, event type, crop step sizes and widths
`ifndef VIDEO_CROP_CONFIG_SVH
`define VIDEO_CROP_CONFIG_SVH

// beam positions and crop offsets
`define VC_COORD_W 12

// geometry change counter
`define VC_GEOM_CNT_W 7

// event type carried with each keyboard/mouse event
`define VC_EVT_KEYBOARD 2'd3

// crop keys
`define VC_KEY_BACKSPACE 8'h41
`define VC_KEY_UP        8'h4C
`define VC_KEY_DOWN      8'h4D
`define VC_KEY_LEFT      8'h4F
`define VC_KEY_RIGHT     8'h4E

// alt modifier, press and release codes
`define VC_KEY_ALT_L_DN 8'h64
`define VC_KEY_ALT_R_DN 8'h65
`define VC_KEY_ALT_L_UP 8'hE4
`define VC_KEY_ALT_R_UP 8'hE5

// offset change per key press
`define VC_HSTEP 4 // pixels
`define VC_VSTEP 1 // lines

`endif

// ==== video_crop_pkg.sv ====
// video crop package: coordinate type and crop command encoding
`include "video_crop_config.svh"

package video_crop_pkg;

	// beam position (unsigned) or crop offset (two's complement)
	typedef logic [`VC_COORD_W-1:0] coord_t;

	// decoded crop key actions
	typedef enum logic [2:0] {
		CMD_CLEAR   = 3'd0, // all offsets back to zero
		CMD_UP      = 3'd1,
		CMD_DOWN    = 3'd2,
		CMD_LEFT    = 3'd3,
		CMD_RIGHT   = 3'd4,
		CMD_ALT_ON  = 3'd5, // either alt pressed
		CMD_ALT_OFF = 3'd6  // either alt released
	} crop_cmd_t;

endpackage

// ==== video_crop_top.sv ====
// video crop top: key decode, offset adjust, beam measure and blank generation
`include "video_crop_config.svh"

module video_crop_top
	import video_crop_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic [7:0]                kbd_data,
	input  logic [1:0]                kbd_type,
	input  logic                      kbd_level,
	input  logic                      hsync_n,
	input  logic                      hblank,
	input  logic                      vblank,
	output logic                      de,
	output coord_t                    h_size,
	output coord_t                    v_size,
	output logic [`VC_GEOM_CNT_W-1:0] geometry_count
);

	// decode to adjust
	logic      cmd_valid;
	crop_cmd_t cmd;

	// current offsets
	coord_t crop_left, crop_right;
	coord_t crop_top, crop_bottom;

	// beam position and active area
	coord_t h_count, v_count;
	coord_t h_act_start, h_act_end;
	coord_t v_act_start, v_act_end;
	logic   line_start;

	crop_key_decode i_key_decode (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.kbd_data  (kbd_data),
		.kbd_type  (kbd_type),
		.kbd_level (kbd_level),
		.cmd_valid (cmd_valid),
		.cmd       (cmd)
	);

	crop_adjust i_adjust (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.crop_left   (crop_left),
		.crop_right  (crop_right),
		.crop_top    (crop_top),
		.crop_bottom (crop_bottom)
	);

	beam_measure i_measure (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.hsync_n        (hsync_n),
		.hblank         (hblank),
		.vblank         (vblank),
		.h_count        (h_count),
		.v_count        (v_count),
		.h_act_start    (h_act_start),
		.h_act_end      (h_act_end),
		.v_act_start    (v_act_start),
		.v_act_end      (v_act_end),
		.line_start     (line_start),
		.h_size         (h_size),
		.v_size         (v_size),
		.geometry_count (geometry_count)
	);

	crop_blank_gen i_blank_gen (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.hsync_n     (hsync_n),
		.h_count     (h_count),
		.v_count     (v_count),
		.h_act_start (h_act_start),
		.h_act_end   (h_act_end),
		.v_act_start (v_act_start),
		.v_act_end   (v_act_end),
		.line_start  (line_start),
		.crop_left   (crop_left),
		.crop_right  (crop_right),
		.crop_top    (crop_top),
		.crop_bottom (crop_bottom),
		.de          (de)
	);

endmodule
